/* wb_cache.f */
common/cache_pkg.sv
cache/cache_ctrl.sv
cache/tag_store.sv
cache/line_store.sv
src/cache_top.sv
verif/tb_clock.sv
verif/tb_mem_model.sv
verif/tb_cache.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the cache testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	-f wb_cache.f \
	--top-module tb_cache \
	-o sim_tb_cache

out="$(./obj_dir/sim_tb_cache || true)"
echo "$out"

if grep -q "TEST PASSED" <<< "$out"; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

/* verif/tb_cache.sv */
`timescale 1ns/1ps

module tb_cache;

	localparam int SET_BITS          = 2;
	localparam int CLK_PERIOD_NS     = 100;
	localparam int MEM_LATENCY       = 3;
	localparam int NUM_LINES         = 64;
	localparam int NUM_WORDS         = NUM_LINES * cache_pkg::WORDS_PER_LINE;
	localparam int WORD_IDX_BITS     = $clog2(NUM_WORDS);
	localparam int RANDOM_OPS        = 2000;
	localparam int DIRECTED_OPS      = 12;
	localparam int WORST_MISS_CYCLES = 2 * (MEM_LATENCY + 1) + 2;   // write-back, fill, retry
	localparam int TIMEOUT_NS        = (RANDOM_OPS + DIRECTED_OPS) * 2 * WORST_MISS_CYCLES
		* CLK_PERIOD_NS + 100 * CLK_PERIOD_NS;

	logic                 clk;
	logic                 rst_n;
	cache_pkg::proc_req_t proc_req;
	cache_pkg::word_t     proc_rdata;
	logic                 proc_stall;
	cache_pkg::mem_req_t  mem_req;
	cache_pkg::line_t     mem_rdata;
	logic                 mem_ready;

	cache_pkg::word_t     golden_mem [NUM_WORDS];
	logic [31:0]          lfsr_q;
	int                   wb_count;
	int                   fill_count;
	cache_pkg::mem_addr_t last_wb_addr;
	logic                 mem_error;

	// written by the compare process only
	int                   completed = 0;
	int                   reads_checked = 0;
	int                   stall_edges = 0;
	int                   mem_active_edges = 0;
	cache_pkg::word_t     last_rdata;

	tb_clock #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(3)) u_clock (
		.clk   (clk),
		.rst_n (rst_n)
	);

	cache_top #(.SET_BITS(SET_BITS)) u_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.proc_req   (proc_req),
		.proc_rdata (proc_rdata),
		.proc_stall (proc_stall),
		.mem_req    (mem_req),
		.mem_rdata  (mem_rdata),
		.mem_ready  (mem_ready)
	);

	tb_mem_model #(.NUM_LINES(NUM_LINES), .LATENCY(MEM_LATENCY)) u_mem (
		.clk          (clk),
		.rst_n        (rst_n),
		.mem_req      (mem_req),
		.mem_rdata    (mem_rdata),
		.mem_ready    (mem_ready),
		.golden       (golden_mem),
		.wb_count     (wb_count),
		.fill_count   (fill_count),
		.last_wb_addr (last_wb_addr),
		.check_error  (mem_error)
	);

	// ------------------------------------------------------------
	// random source and reference
	// ------------------------------------------------------------
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32+x^22+x^2+x+1
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int k = 0; k < n; k++) begin
			lfsr_q = lfsr_next(lfsr_q);
			r = {r[30:0], lfsr_q[0]};
		end
		return r;
	endfunction

	function automatic cache_pkg::word_t expected_word(input cache_pkg::proc_addr_t a);
		return golden_mem[a[WORD_IDX_BITS-1:0]];
	endfunction

	function automatic cache_pkg::proc_addr_t line_addr(input int line, input int word);
		cache_pkg::proc_addr_t a;
		a = '0;
		a[WORD_IDX_BITS-1:2] = 6'(line);
		a[1:0] = 2'(word);
		return a;
	endfunction

	// ------------------------------------------------------------
	// compare tasks
	// ------------------------------------------------------------
	task automatic check_word(input cache_pkg::word_t got, input cache_pkg::word_t exp,
			input string what);
		if (got !== exp) begin
			$display("** Error @ %0t: %s: got %h, expected %h", $time, what, got, exp);
			$display("TEST FAILED");
			$fatal(1, "word mismatch");
		end
	endtask

	task automatic check_addr(input cache_pkg::mem_addr_t got, input cache_pkg::mem_addr_t exp,
			input string what);
		if (got !== exp) begin
			$display("** Error @ %0t: %s: got %h, expected %h", $time, what, got, exp);
			$display("TEST FAILED");
			$fatal(1, "address mismatch");
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("** Error @ %0t: %s: got %b, expected %b", $time, what, got, exp);
			$display("TEST FAILED");
			$fatal(1, "flag mismatch");
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp) begin
			$display("** Error @ %0t: %s: got %0d, expected %0d", $time, what, got, exp);
			$display("TEST FAILED");
			$fatal(1, "count mismatch");
		end
	endtask

	// ------------------------------------------------------------
	// stimulus helpers, called on a falling edge
	// ------------------------------------------------------------
	task automatic issue_access(input logic is_write, input cache_pkg::proc_addr_t addr,
			input cache_pkg::word_t wdata);
		int prev;
		prev = completed;
		proc_req.read  = !is_write;
		proc_req.write = is_write;
		proc_req.addr  = addr;
		proc_req.wdata = wdata;
		while (completed == prev) begin
			@(negedge clk);   // held until the compare process sees it complete
		end
		if (is_write) begin
			golden_mem[addr[WORD_IDX_BITS-1:0]] = wdata;
		end
		proc_req = '0;
	endtask

	task automatic read_at(input int line, input int word);
		issue_access(1'b0, line_addr(line, word), '0);
	endtask

	task automatic write_at(input int line, input int word, input cache_pkg::word_t d);
		issue_access(1'b1, line_addr(line, word), d);
	endtask

	// ------------------------------------------------------------
	// compare process
	// ------------------------------------------------------------
	always @(posedge clk) begin
		if (rst_n) begin
			check_bit(mem_req.read & mem_req.write, 1'b0, "memory read and write together");
			if (mem_req.read || mem_req.write) begin
				mem_active_edges++;
			end
			if ((proc_req.read || proc_req.write) && proc_stall) begin
				stall_edges++;
			end
			if ((proc_req.read || proc_req.write) && !proc_stall) begin
				if (proc_req.read) begin
					check_word(proc_rdata, expected_word(proc_req.addr), "read data");
					last_rdata = proc_rdata;
					reads_checked++;
				end
				completed++;
			end
		end
	end

	always @(posedge mem_error) begin
		$display("TEST FAILED");
		$fatal(1, "memory model reported an error");
	end

	initial begin
		#(TIMEOUT_NS);
		$display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
		$display("TEST FAILED");
		$fatal(1, "watchdog expired");
	end

	// ------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------
	initial begin
		int s0;
		int m0;
		int wb0;
		int fill0;
		logic is_wr;
		cache_pkg::word_t wval;
		proc_req = '0;
		lfsr_q   = 32'h21b35e7b;
		for (int i = 0; i < NUM_WORDS; i++) begin
			golden_mem[i] = take_bits(32);
		end
		wait (rst_n);
		@(negedge clk);

		// cold read, empty victim so no write-back
		s0    = stall_edges;
		wb0   = wb_count;
		fill0 = fill_count;
		read_at(5, 2);
		check_bit(stall_edges > s0, 1'b1, "stall on cold read");
		check_count(wb_count, wb0, "write-backs on cold read");
		check_count(fill_count, fill0 + 1, "fills on cold read");

		// repeat hit, no memory traffic
		s0 = stall_edges;
		m0 = mem_active_edges;
		read_at(5, 0);
		check_count(stall_edges, s0, "stall edges on read hit");
		check_count(mem_active_edges, m0, "memory cycles on read hit");

		// write hit then read back
		wval = 32'h5eedc0de;
		s0   = stall_edges;
		write_at(5, 1, wval);
		read_at(5, 1);
		check_count(stall_edges, s0, "stall edges on write hit");
		check_word(last_rdata, wval, "read after write hit");

		// three tags in set 3, line 7 ends up lru and dirty with a write
		read_at(3, 0);
		read_at(7, 0);
		wval = 32'hc0ffee11;
		write_at(7, 3, wval);
		read_at(3, 1);
		wb0 = wb_count;
		read_at(11, 2);
		check_count(wb_count, wb0 + 1, "write-backs on eviction");
		check_addr(last_wb_addr, 28'd7, "evicted line address");
		read_at(3, 0);
		read_at(7, 3);
		check_word(last_rdata, wval, "written word after eviction and refill");
		read_at(11, 2);

		// random mix over 64 lines
		for (int i = 0; i < RANDOM_OPS; i++) begin
			is_wr = take_bits(1) == 32'd1;
			s0    = int'(take_bits(6));
			m0    = int'(take_bits(2));
			wval  = take_bits(32);
			issue_access(is_wr, line_addr(s0, m0), wval);
		end

		@(negedge clk);
		if (reads_checked < RANDOM_OPS / 4) begin
			$display("only %0d reads were checked", reads_checked);
			$display("TEST FAILED");
			$fatal(1, "too few reads");
		end else begin
			$display("TEST PASSED");
			$finish;
		end
	end

endmodule

/* verif/tb_mem_model.sv */
`timescale 1ns/1ps

module tb_mem_model #(
	parameter int NUM_LINES = 64,
	parameter int LATENCY   = 3
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  cache_pkg::mem_req_t  mem_req,
	output cache_pkg::line_t     mem_rdata,
	output logic                 mem_ready,
	input  cache_pkg::word_t     golden [NUM_LINES*cache_pkg::WORDS_PER_LINE],
	output int                   wb_count,
	output int                   fill_count,
	output cache_pkg::mem_addr_t last_wb_addr,
	output logic                 check_error
);

	localparam int NUM_WORDS = NUM_LINES * cache_pkg::WORDS_PER_LINE;
	localparam int WORD_BITS = $bits(cache_pkg::word_t);

	cache_pkg::word_t mem [NUM_WORDS];   // backing store, loaded during reset
	cache_pkg::line_t rdata_q = '0;
	logic             ready_q = 1'b0;
	logic             error_q = 1'b0;
	int               wait_cnt = 0;

	assign mem_rdata   = rdata_q;
	assign mem_ready   = ready_q;
	assign check_error = error_q;

	function automatic cache_pkg::line_t mem_line(input int base);
		cache_pkg::line_t l;
		for (int w = 0; w < cache_pkg::WORDS_PER_LINE; w++) begin
			l[w*WORD_BITS +: WORD_BITS] = mem[base + w];
		end
		return l;
	endfunction

	function automatic cache_pkg::line_t golden_line(input int base);
		cache_pkg::line_t l;
		for (int w = 0; w < cache_pkg::WORDS_PER_LINE; w++) begin
			l[w*WORD_BITS +: WORD_BITS] = golden[base + w];
		end
		return l;
	endfunction

	task automatic check_line(input cache_pkg::line_t got, input cache_pkg::line_t exp,
			input cache_pkg::mem_addr_t addr);
		if (got !== exp) begin
			$display("** Error @ %0t: write-back of line %0h: got %h, expected %h",
				$time, addr, got, exp);
			error_q = 1'b1;
		end
	endtask

	// ------------------------------------------------------------
	// request handling, one ready pulse per request
	// ------------------------------------------------------------
	always @(negedge clk) begin
		int base;
		if (!rst_n) begin
			for (int i = 0; i < NUM_WORDS; i++) begin
				mem[i] = golden[i];
			end
			ready_q  <= 1'b0;
			wait_cnt = 0;
		end else if (ready_q) begin
			ready_q  <= 1'b0;    // pulse is one cycle
			wait_cnt = 0;
		end else if (mem_req.read || mem_req.write) begin
			if (int'(mem_req.addr) >= NUM_LINES) begin
				$display("memory request for line %0h lies outside the %0d-line test memory",
					mem_req.addr, NUM_LINES);
				error_q = 1'b1;
			end else if (wait_cnt == LATENCY - 1) begin
				base = int'(mem_req.addr) * cache_pkg::WORDS_PER_LINE;
				if (mem_req.write) begin
					check_line(mem_req.wdata, golden_line(base), mem_req.addr);
					for (int w = 0; w < cache_pkg::WORDS_PER_LINE; w++) begin
						mem[base + w] = mem_req.wdata[w*WORD_BITS +: WORD_BITS];
					end
					wb_count++;
					last_wb_addr = mem_req.addr;
				end else begin
					rdata_q <= mem_line(base);
					fill_count++;
				end
				ready_q <= 1'b1;
			end else begin
				wait_cnt++;
			end
		end
	end

endmodule

/* verif/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
	parameter int PERIOD_NS    = 100,
	parameter int RESET_CYCLES = 3
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// release on a falling edge, away from the sampling edge
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

/* src/cache_top.sv */
`timescale 1ns/1ps

module cache_top #(
	parameter int SET_BITS = 2
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  cache_pkg::proc_req_t proc_req,
	output cache_pkg::word_t     proc_rdata,
	output logic                 proc_stall,
	output cache_pkg::mem_req_t  mem_req,
	input  cache_pkg::line_t     mem_rdata,
	input  logic                 mem_ready
);

	localparam int TAG_BITS = $bits(cache_pkg::mem_addr_t) - SET_BITS;

	// ------------------------------------------------------------
	// internal wiring
	// ------------------------------------------------------------
	logic                hit;
	logic                access_way;     // hit way, else victim way
	logic                victim_valid;
	logic [TAG_BITS-1:0] victim_tag;
	logic                wr_en;
	logic                touch_en;
	logic                fill_en;
	cache_pkg::line_t    victim_line;

	cache_ctrl #(.SET_BITS(SET_BITS)) u_ctrl (
		.clk          (clk),
		.rst_n        (rst_n),
		.proc_req     (proc_req),
		.hit          (hit),
		.victim_valid (victim_valid),
		.victim_tag   (victim_tag),
		.victim_line  (victim_line),
		.mem_ready    (mem_ready),
		.proc_stall   (proc_stall),
		.wr_en        (wr_en),
		.touch_en     (touch_en),
		.fill_en      (fill_en),
		.mem_req      (mem_req)
	);

	tag_store #(.SET_BITS(SET_BITS)) u_tags (
		.clk          (clk),
		.rst_n        (rst_n),
		.addr         (proc_req.addr),
		.touch_en     (touch_en),
		.fill_en      (fill_en),
		.hit          (hit),
		.access_way   (access_way),
		.victim_valid (victim_valid),
		.victim_tag   (victim_tag)
	);

	line_store #(.SET_BITS(SET_BITS)) u_lines (
		.clk          (clk),
		.addr         (proc_req.addr),
		.access_way   (access_way),
		.wr_en        (wr_en),
		.fill_en      (fill_en),
		.wdata        (proc_req.wdata),
		.fill_line    (mem_rdata),     // fill straight from memory
		.rd_word      (proc_rdata),
		.victim_line  (victim_line)
	);

endmodule

/* cache/line_store.sv */
`timescale 1ns/1ps

module line_store #(
	parameter int SET_BITS = 2
) (
	input  logic                  clk,
	input  cache_pkg::proc_addr_t addr,
	input  logic                  access_way,
	input  logic                  wr_en,
	input  logic                  fill_en,
	input  cache_pkg::word_t      wdata,
	input  cache_pkg::line_t      fill_line,
	output cache_pkg::word_t      rd_word,
	output cache_pkg::line_t      victim_line
);

	localparam int OFFSET_BITS = $clog2(cache_pkg::WORDS_PER_LINE);
	localparam int WORD_BITS   = $bits(cache_pkg::word_t);
	localparam int NUM_SETS    = 1 << SET_BITS;

	// ------------------------------------------------------------
	// data array, guarded by the valid bits in tag_store
	// ------------------------------------------------------------
	cache_pkg::line_t data_q [NUM_SETS][2];

	logic [SET_BITS-1:0]    set_idx;
	logic [OFFSET_BITS-1:0] word_sel;
	cache_pkg::line_t       cur_line;
	cache_pkg::line_t       next_line;

	assign word_sel = addr[OFFSET_BITS-1:0];
	assign set_idx  = addr[OFFSET_BITS +: SET_BITS];
	assign cur_line = data_q[set_idx][access_way];

	// merge the write word into the current line, or take the fill
	always_comb begin
		next_line = cur_line;
		if (fill_en) begin
			next_line = fill_line;
		end else begin
			for (int w = 0; w < cache_pkg::WORDS_PER_LINE; w++) begin
				if (w == int'(word_sel)) begin
					next_line[w*WORD_BITS +: WORD_BITS] = wdata;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fill_en || wr_en) begin
			data_q[set_idx][access_way] <= next_line;
		end
	end

	// ------------------------------------------------------------
	// read side
	// ------------------------------------------------------------
	assign victim_line = cur_line;     // whole line for write-back

	always_comb begin
		rd_word = cur_line[WORD_BITS-1:0];
		for (int w = 1; w < cache_pkg::WORDS_PER_LINE; w++) begin
			if (w == int'(word_sel)) begin
				rd_word = cur_line[w*WORD_BITS +: WORD_BITS];
			end
		end
	end

endmodule

/* cache/tag_store.sv */
`timescale 1ns/1ps

module tag_store #(
	parameter int SET_BITS = 2
) (
	input  logic                                           clk,
	input  logic                                           rst_n,
	input  cache_pkg::proc_addr_t                          addr,
	input  logic                                           touch_en,
	input  logic                                           fill_en,
	output logic                                           hit,
	output logic                                           access_way,
	output logic                                           victim_valid,
	output logic [$bits(cache_pkg::mem_addr_t)-SET_BITS-1:0] victim_tag
);

	localparam int OFFSET_BITS = $clog2(cache_pkg::WORDS_PER_LINE);
	localparam int TAG_BITS    = $bits(cache_pkg::mem_addr_t) - SET_BITS;
	localparam int NUM_SETS    = 1 << SET_BITS;

	// ------------------------------------------------------------
	// storage
	// ------------------------------------------------------------
	logic [TAG_BITS-1:0]      tag_q [NUM_SETS][2];
	logic [NUM_SETS-1:0][1:0] valid_q;
	logic [NUM_SETS-1:0]      lru_q;    // holds the least recently used way

	logic [SET_BITS-1:0] set_idx;
	logic [TAG_BITS-1:0] req_tag;
	logic [1:0]          way_hit;
	logic                victim_way;

	assign set_idx = addr[OFFSET_BITS +: SET_BITS];
	assign req_tag = addr[OFFSET_BITS+SET_BITS +: TAG_BITS];

	// ------------------------------------------------------------
	// lookup
	// ------------------------------------------------------------
	always_comb begin
		for (int w = 0; w < 2; w++) begin
			way_hit[w] = valid_q[set_idx][w] && (tag_q[set_idx][w] == req_tag);
		end
	end

	assign hit = |way_hit;

	// empty ways first, then lru
	always_comb begin
		if (!valid_q[set_idx][0]) begin
			victim_way = 1'b0;
		end else if (!valid_q[set_idx][1]) begin
			victim_way = 1'b1;
		end else begin
			victim_way = lru_q[set_idx];
		end
	end

	assign access_way   = hit ? way_hit[1] : victim_way;
	assign victim_valid = valid_q[set_idx][victim_way];
	assign victim_tag   = tag_q[set_idx][victim_way];

	// ------------------------------------------------------------
	// update
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= '0;
			lru_q   <= '0;
		end else begin
			if (touch_en || fill_en) begin
				lru_q[set_idx] <= ~access_way;  // other way becomes lru
			end
			if (fill_en) begin
				valid_q[set_idx][access_way] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fill_en) begin
			tag_q[set_idx][access_way] <= req_tag;
		end
	end

	// a line must never live in both ways of one set
	a_no_dup_tag: assert property (@(posedge clk) disable iff (!rst_n)
		!((&valid_q[set_idx]) && (tag_q[set_idx][0] == tag_q[set_idx][1])));

endmodule

/* cache/cache_ctrl.sv */
`timescale 1ns/1ps

module cache_ctrl #(
	parameter int SET_BITS = 2
) (
	input  logic                                           clk,
	input  logic                                           rst_n,
	input  cache_pkg::proc_req_t                           proc_req,
	input  logic                                           hit,
	input  logic                                           victim_valid,
	input  logic [$bits(cache_pkg::mem_addr_t)-SET_BITS-1:0] victim_tag,
	input  cache_pkg::line_t                               victim_line,
	input  logic                                           mem_ready,
	output logic                                           proc_stall,
	output logic                                           wr_en,
	output logic                                           touch_en,
	output logic                                           fill_en,
	output cache_pkg::mem_req_t                            mem_req
);

	localparam int OFFSET_BITS = $clog2(cache_pkg::WORDS_PER_LINE);
	localparam int ADDR_BITS   = $bits(cache_pkg::proc_addr_t);

	cache_pkg::cache_state_e state_q;
	cache_pkg::cache_state_e state_d;

	logic                req_valid;
	logic [SET_BITS-1:0] set_idx;
	logic                ready_hit;

	assign req_valid = proc_req.read | proc_req.write;
	assign set_idx   = proc_req.addr[OFFSET_BITS +: SET_BITS];
	assign ready_hit = (state_q == cache_pkg::ST_READY) && hit;

	// ------------------------------------------------------------
	// state register and sequencing
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= cache_pkg::ST_READY;
		end else begin
			state_q <= state_d;
		end
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			cache_pkg::ST_READY: begin
				// skip write-back when the victim way is empty
				if (req_valid && !hit) begin
					state_d = victim_valid ? cache_pkg::ST_WRITEBACK : cache_pkg::ST_FILL;
				end
			end
			cache_pkg::ST_WRITEBACK: begin
				if (mem_ready) begin
					state_d = cache_pkg::ST_FILL;
				end
			end
			cache_pkg::ST_FILL: begin
				if (mem_ready) begin
					state_d = cache_pkg::ST_READY;
				end
			end
			default: state_d = cache_pkg::ST_READY;
		endcase
	end

	// ------------------------------------------------------------
	// requester side and store strobes
	// ------------------------------------------------------------
	assign proc_stall = req_valid && !ready_hit;    // combinational on a miss
	assign wr_en      = ready_hit && proc_req.write;
	assign touch_en   = ready_hit && req_valid;
	assign fill_en    = (state_q == cache_pkg::ST_FILL) && mem_ready;

	// memory request, held as a level until mem_ready
	always_comb begin
		mem_req = '0;
		case (state_q)
			cache_pkg::ST_WRITEBACK: begin
				mem_req.write = 1'b1;
				mem_req.addr  = {victim_tag, set_idx};  // victim's own line address
				mem_req.wdata = victim_line;
			end
			cache_pkg::ST_FILL: begin
				mem_req.read = 1'b1;
				mem_req.addr = proc_req.addr[ADDR_BITS-1:OFFSET_BITS];
			end
			default: begin
				mem_req = '0;
			end
		endcase
	end

	// ------------------------------------------------------------
	// checks
	// ------------------------------------------------------------
	a_mem_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(mem_req.read && mem_req.write));

	// requester must hold its request across the whole miss
	a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
		proc_stall |=> $stable(proc_req));

	// the cycle after a fill the held request must hit in the tag store
	a_fill_hit: assert property (@(posedge clk) disable iff (!rst_n)
		fill_en |=> (hit && !proc_stall));

endmodule

/* common/cache_pkg.sv */
package cache_pkg;

	// ------------------------------------------------------------
	// cache geometry and data types
	// ------------------------------------------------------------
	localparam int WORDS_PER_LINE = 4;

	typedef logic [31:0] word_t;

	// word 0 sits in the low bits
	typedef logic [WORDS_PER_LINE*$bits(word_t)-1:0] line_t;

	typedef logic [29:0] proc_addr_t;   // {tag, set, word}
	typedef logic [27:0] mem_addr_t;    // line address, no word bits

	// ------------------------------------------------------------
	// request bundles
	// ------------------------------------------------------------
	typedef struct packed {
		logic       read;
		logic       write;
		proc_addr_t addr;
		word_t      wdata;
	} proc_req_t;

	typedef struct packed {
		logic      read;
		logic      write;
		mem_addr_t addr;
		line_t     wdata;    // write-back line
	} mem_req_t;

	// miss sequencer
	typedef enum logic [1:0] {
		ST_READY     = 2'd0,
		ST_WRITEBACK = 2'd1,
		ST_FILL      = 2'd2
	} cache_state_e;

endpackage
